/* build.f */
+incdir+rtl
rtl/prot_isa_pkg.sv
rtl/prot_bus_pkg.sv
rtl/prot_dpram.sv
rtl/prot_irq.sv
rtl/prot_bus.sv
rtl/prot_core.sv
rtl/prot_top.sv
verification/prot_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the protection coprocessor testbench with Verilator
# exit status is nonzero when the testbench stops with $fatal
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    -f build.f \
    --top-module prot_tb \
    --Mdir obj_dir \
    -o prot_sim

./obj_dir/prot_sim

/* verification/prot_tb.sv */
// protection coprocessor testbench
// loads a small program through the programming port, then applies
// a table of main-side steps: writes, checked reads, mailbox kicks
// and polls of the done flag, checked against a reference model
`include "prot_config.svh"

module prot_tb;

    localparam int STEP_LIMIT = 300;                  // cycles, worst single step
    localparam int POLL_GAP   = 8;                    // cycles between flag reads
    localparam int KICK_GAP   = `PROT_IRQ_HOLD + 16;  // old irq hold must be over

    typedef enum logic [2:0] {K_WR, K_RD, K_KICK, K_POLL, K_IDLE} step_kind_e;

    typedef struct packed {
        step_kind_e              kind;
        logic [`PROT_RAM_AW-1:0] addr;
        logic [7:0]              data;   // write data, expected read or idle count
    } step_t;

    logic                     clk = 1'b0;
    logic                     rst_n;
    logic [`PROT_RAM_AW-1:0]  main_addr;
    logic [7:0]               main_dout;
    logic [7:0]               main_din;
    logic                     main_cs;
    logic                     main_wrn;
    logic [`PROT_PROG_AW-1:0] prog_addr;
    logic [15:0]              prog_data;
    logic                     prog_en;

    step_t                   steps[$];
    logic [15:0]             prog[$];
    logic [7:0]              shadow[2**`PROT_RAM_AW];   // what main last wrote
    logic [`PROT_RAM_AW-1:0] known[$];                  // addresses safe to re-read
    logic [31:0]             rng = 32'h2e5f;
    logic [7:0]              key;
    int                      cycle = 0;
    int                      last_kick = 0;
    bit                      table_ready = 1'b0;

    prot_top dut0 (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .main_addr ( main_addr ),
        .main_dout ( main_dout ),
        .main_din  ( main_din  ),
        .main_cs   ( main_cs   ),
        .main_wrn  ( main_wrn  ),
        .prog_addr ( prog_addr ),
        .prog_data ( prog_data ),
        .prog_en   ( prog_en   )
    );

    always #2 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [7:0] rand_byte();
        rng = xorshift32(rng);
        return rng[15:8];
    endfunction

    function automatic logic [15:0] encode(prot_isa_pkg::opcode_e op, logic [11:0] field);
        return {op, field};
    endfunction

    task automatic stop_run();
        $display("Some tests failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(string name, logic [7:0] exp, logic [7:0] act);
        if (act !== exp) begin
            $display("[FAIL] time %0t %s expected %02h got %02h", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic add_write(logic [`PROT_RAM_AW-1:0] a, logic [7:0] d);
        steps.push_back({K_WR, a, d});
        shadow[a] = d;
    endtask

    task automatic add_read(logic [`PROT_RAM_AW-1:0] a, logic [7:0] d);
        steps.push_back({K_RD, a, d});
    endtask

    // one request: operands, flag clear, kick, optional lead and read burst, result
    task automatic add_round(int lead, int burst);
        logic [7:0]              op_a;
        logic [7:0]              op_b;
        logic [7:0]              sum;
        logic [`PROT_RAM_AW-1:0] a;
        op_a = rand_byte();
        op_b = rand_byte();
        sum  = op_a + op_b;   // wraps at 256
        add_write(11'h000, op_a);
        add_write(11'h001, op_b);
        add_write(11'h003, 8'h00);   // done flag
        steps.push_back({K_KICK, `PROT_MAILBOX, rand_byte()});
        if (lead > 0) begin
            steps.push_back({K_IDLE, 11'h000, 8'(lead)});   // core runs into the job
        end
        for (int i = 0; i < burst; i++) begin
            a = known[i % known.size()];
            add_read(a, shadow[a]);   // core frozen meanwhile
        end
        steps.push_back({K_POLL, 11'h003, 8'h00});
        add_read(11'h003, 8'h01);
        add_read(11'h002, sum ^ key);
    endtask

    task automatic build_program();
        prog.push_back(encode(prot_isa_pkg::LDI, {4'h0, key}));
        prog.push_back(encode(prot_isa_pkg::ST, 12'h010));     // key into work ram
        prog.push_back(encode(prot_isa_pkg::WAI, 12'h000));    // 2: wait irq high
        prog.push_back(encode(prot_isa_pkg::LD, 12'h800));
        prog.push_back(encode(prot_isa_pkg::ADD, 12'h801));
        prog.push_back(encode(prot_isa_pkg::XOR, 12'h010));
        prog.push_back(encode(prot_isa_pkg::ST, 12'h802));     // result
        prog.push_back(encode(prot_isa_pkg::LDI, 12'h001));
        prog.push_back(encode(prot_isa_pkg::ST, 12'h803));     // done flag
        prog.push_back(encode(prot_isa_pkg::WAI, 12'h001));    // wait irq low
        prog.push_back(encode(prot_isa_pkg::JMP, 12'h002));
    endtask

    task automatic build_table();
        logic [7:0]              d;
        logic [`PROT_RAM_AW-1:0] a;
        known.push_back(11'h000);
        known.push_back(11'h001);
        // plain shared ram traffic
        for (int i = 0; i < 8; i++) begin
            d = rand_byte();
            a = {3'b010, i[3:0], d[3:0]};
            add_write(a, rand_byte());
            add_read(a, shadow[a]);
            known.push_back(a);
        end
        add_round(0, 0);
        // same low addresses as the key in work ram
        for (int i = 0; i < 3; i++) begin
            a = 11'h00f + 11'(i);
            add_write(a, rand_byte());
            known.push_back(a);
        end
        for (int i = 0; i < 3; i++) begin
            add_read(11'h00f + 11'(i), shadow[11'h00f + 11'(i)]);
        end
        add_round(0, 0);
        repeat (3) add_round(0, 0);   // irq reload between rounds
        add_round(3, 24);   // burst lands in the LD data cycle
        add_round(6, 40);   // burst lands in the ADD data cycle
    endtask

    task automatic release_bus();
        main_cs  = 1'b0;
        main_wrn = 1'b1;
    endtask

    // access tasks start right after a falling edge and end on one
    task automatic do_write(logic [`PROT_RAM_AW-1:0] a, logic [7:0] d);
        main_addr = a;
        main_dout = d;
        main_wrn  = 1'b0;
        main_cs   = 1'b1;
        @(negedge clk);
    endtask

    task automatic do_read(logic [`PROT_RAM_AW-1:0] a, logic [7:0] exp);
        main_addr = a;
        main_wrn  = 1'b1;
        main_cs   = 1'b1;
        @(negedge clk);
        check_value($sformatf("main_din[%03h]", a), exp, main_din);
    endtask

    // bus left to the core for n cycles
    task automatic idle_cycles(logic [7:0] n);
        release_bus();
        repeat (n) @(negedge clk);
    endtask

    task automatic kick_mailbox(logic [7:0] d);
        release_bus();
        while (cycle - last_kick < KICK_GAP) begin
            @(negedge clk);   // core back at its first WAI
        end
        last_kick = cycle;
        do_write(`PROT_MAILBOX, d);
    endtask

    task automatic poll_nonzero(logic [`PROT_RAM_AW-1:0] a);
        int         tries;
        logic [7:0] val;
        tries = 0;
        val   = 8'h00;
        while (val == 8'h00) begin
            if (tries >= STEP_LIMIT / POLL_GAP) begin
                $display("shared byte %03h stayed zero, computation never finished", a);
                stop_run();
            end else begin
                tries++;
                release_bus();
                repeat (POLL_GAP - 1) @(negedge clk);   // let the core run
                main_addr = a;
                main_wrn  = 1'b1;
                main_cs   = 1'b1;
                @(negedge clk);
                val = main_din;
            end
        end
        release_bus();
    endtask

    initial begin
        wait (table_ready);
        repeat (steps.size() * STEP_LIMIT + `PROT_IRQ_HOLD + prog.size() + 3) @(posedge clk);
        $display("watchdog expired before the step table completed");
        stop_run();
    end

    initial begin
        rst_n     = 1'b0;
        main_addr = '0;
        main_dout = 8'h00;
        main_cs   = 1'b0;
        main_wrn  = 1'b1;
        prog_addr = '0;
        prog_data = 16'h0000;
        prog_en   = 1'b0;
        key = rand_byte();
        build_program();
        build_table();
        table_ready = 1'b1;
        // rom load with the core in reset
        foreach (prog[i]) begin
            @(negedge clk);
            prog_en   = 1'b1;
            prog_addr = `PROT_PROG_AW'(i);
            prog_data = prog[i];
        end
        @(negedge clk);
        prog_en = 1'b0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        foreach (steps[i]) begin
            case (steps[i].kind)
                K_WR:    do_write(steps[i].addr, steps[i].data);
                K_RD:    do_read(steps[i].addr, steps[i].data);
                K_KICK:  kick_mailbox(steps[i].data);
                K_IDLE:  idle_cycles(steps[i].data);
                default: poll_nonzero(steps[i].addr);
            endcase
        end
        release_bus();
        $display("All tests passed");
        $finish;
    end

endmodule

/* rtl/prot_top.sv */
// protection coprocessor top level
// main cpu sees only the 2 kB shared ram, the mailbox byte
// interrupts the coprocessor, which computes on the shared data
// and writes results back
`include "prot_config.svh"

module prot_top (
    input  logic                     clk,
    input  logic                     rst_n,
    // main cpu port, shared ram only
    input  logic [`PROT_RAM_AW-1:0]  main_addr,
    input  logic [7:0]               main_dout,
    output logic [7:0]               main_din,
    input  logic                     main_cs,
    input  logic                     main_wrn,
    // program rom loading
    input  logic [`PROT_PROG_AW-1:0] prog_addr,
    input  logic [15:0]              prog_data,
    input  logic                     prog_en
);

    logic                    irq;
    prot_bus_pkg::bus_addr_t bus_addr;
    logic [7:0]              bus_wdata;
    logic [7:0]              bus_rdata;
    logic                    bus_rd;
    logic                    bus_wr;
    logic [`PROT_RAM_AW-1:0] shd_addr;
    logic [7:0]              shd_wdata;
    logic [7:0]              shd_q;
    logic                    shd_we;

    prot_core u_core (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .prog_addr ( prog_addr ),
        .prog_data ( prog_data ),
        .prog_en   ( prog_en   ),
        .irq       ( irq       ),
        .main_cs   ( main_cs   ),   // wait line
        .bus_rdata ( bus_rdata ),
        .bus_addr  ( bus_addr  ),
        .bus_wdata ( bus_wdata ),
        .bus_rd    ( bus_rd    ),
        .bus_wr    ( bus_wr    )
    );

    prot_bus u_bus (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .bus_addr  ( bus_addr  ),
        .bus_wdata ( bus_wdata ),
        .bus_rd    ( bus_rd    ),
        .bus_wr    ( bus_wr    ),
        .bus_rdata ( bus_rdata ),
        .shd_addr  ( shd_addr  ),
        .shd_wdata ( shd_wdata ),
        .shd_we    ( shd_we    ),
        .shd_q     ( shd_q     )
    );

    // port a main, port b coprocessor
    prot_dpram #(
        .aw ( `PROT_RAM_AW ),
        .dw ( 8            )
    ) u_shared (
        .clk     ( clk                  ),
        .addr_a  ( main_addr            ),
        .wdata_a ( main_dout            ),
        .we_a    ( main_cs && !main_wrn ),
        .q_a     ( main_din             ),
        .addr_b  ( shd_addr             ),
        .wdata_b ( shd_wdata            ),
        .we_b    ( shd_we               ),
        .q_b     ( shd_q                )
    );

    prot_irq u_irq (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .main_addr ( main_addr ),
        .main_cs   ( main_cs   ),
        .irq       ( irq       )
    );

endmodule

/* rtl/prot_core.sv */
// protection coprocessor core
// small accumulator engine running from a 512x16 program rom
// loaded through the programming port, sequenced as
// fetch, issue, data (reads only), with a halted state
// the whole core freezes while main_cs is high
`include "prot_config.svh"

module prot_core (
    input  logic                     clk,
    input  logic                     rst_n,
    // programming port
    input  logic [`PROT_PROG_AW-1:0] prog_addr,
    input  logic [15:0]              prog_data,
    input  logic                     prog_en,
    // control
    input  logic                     irq,
    input  logic                     main_cs,   // main owns the bus, core waits
    // data bus
    input  logic [7:0]               bus_rdata,
    output prot_bus_pkg::bus_addr_t  bus_addr,
    output logic [7:0]               bus_wdata,
    output logic                     bus_rd,
    output logic                     bus_wr
);

    typedef enum logic [1:0] {
        S_FETCH,
        S_ISSUE,
        S_DATA,
        S_HALT
    } state_e;

    state_e                   state;
    logic [15:0]              rom [2**`PROT_PROG_AW];
    logic [15:0]              rom_q;       // doubles as instruction register
    prot_isa_pkg::instr_u     ir;
    prot_isa_pkg::opcode_e    op;
    logic [`PROT_PROG_AW-1:0] pc;
    logic [`PROT_PROG_AW-1:0] target;      // jump destination
    logic [7:0]               acc;
    logic                     rd_q;        // read strobe seen last edge
    logic                     run;         // not frozen this cycle
    logic                     rd_op;
    logic                     wait_done;

    assign run    = !main_cs;
    assign ir     = rom_q;
    assign op     = ir.mem.op;
    assign target = ir.mem.addr[`PROT_PROG_AW-1:0];

    assign rd_op = (op == prot_isa_pkg::LD) || (op == prot_isa_pkg::ADD) ||
                   (op == prot_isa_pkg::XOR);

    // WAI level select
    // addr[0]=0 waits for irq high, addr[0]=1 waits for irq low
    assign wait_done = irq ^ ir.mem.addr[0];

    assign bus_addr  = ir.mem.addr;
    assign bus_wdata = acc;   // only ST writes

    // strobes only when not frozen
    // a read cut off by a freeze is issued again from S_DATA
    assign bus_rd = run && (((state == S_ISSUE) && rd_op) ||
                            ((state == S_DATA) && !rd_q));
    assign bus_wr = run && (state == S_ISSUE) && (op == prot_isa_pkg::ST);

    // program rom, writable any time, also during reset
    always_ff @(posedge clk) begin
        if (prog_en) begin
            rom[prog_addr] <= prog_data;
        end
        if (run && (state == S_FETCH)) begin
            rom_q <= rom[pc];   // held through issue and data
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= S_FETCH;
            pc    <= '0;
            acc   <= 8'd0;
            rd_q  <= 1'b0;
        end else begin
            rd_q <= bus_rd;   // tracks the bus, not the core
            if (run) begin
                case (state)
                    S_FETCH: state <= S_ISSUE;
                    S_ISSUE: begin
                        state <= S_FETCH;
                        pc    <= pc + 1'b1;   // default next word
                        case (op)
                            prot_isa_pkg::LDI: acc <= ir.imm.imm;
                            prot_isa_pkg::LD,
                            prot_isa_pkg::ADD,
                            prot_isa_pkg::XOR: state <= S_DATA;
                            prot_isa_pkg::JMP: pc <= target;
                            prot_isa_pkg::JZ: begin
                                if (acc == 8'd0) begin
                                    pc <= target;
                                end
                            end
                            prot_isa_pkg::WAI: begin
                                if (!wait_done) begin
                                    pc    <= pc;        // spin on this word
                                    state <= S_ISSUE;
                                end
                            end
                            prot_isa_pkg::HALT: begin
                                pc    <= pc;
                                state <= S_HALT;
                            end
                            default: ;   // NOP, ST, spare codes
                        endcase
                    end
                    S_DATA: begin
                        if (rd_q) begin   // bus_rdata valid now
                            case (op)
                                prot_isa_pkg::LD:  acc <= bus_rdata;
                                prot_isa_pkg::ADD: acc <= acc + bus_rdata;   // mod 256
                                default:           acc <= acc ^ bus_rdata;
                            endcase
                            state <= S_FETCH;
                        end
                    end
                    default: ;   // halted until reset
                endcase
            end
        end
    end

endmodule

/* rtl/prot_bus.sv */
// coprocessor data bus
// decodes the core address into work ram or shared ram,
// holds the private work ram and returns read data one cycle
// after the read strobe, 0xff when nothing was read
`include "prot_config.svh"

module prot_bus (
    input  logic                    clk,
    input  logic                    rst_n,
    // core side
    input  prot_bus_pkg::bus_addr_t bus_addr,
    input  logic [7:0]              bus_wdata,
    input  logic                    bus_rd,
    input  logic                    bus_wr,
    output logic [7:0]              bus_rdata,
    // shared ram port b
    output logic [`PROT_RAM_AW-1:0] shd_addr,
    output logic [7:0]              shd_wdata,
    output logic                    shd_we,
    input  logic [7:0]              shd_q
);

    prot_bus_pkg::region_e region;
    prot_bus_pkg::region_e rd_region;   // region of the read in flight
    logic                  rd_pend;     // read issued last cycle
    logic                  work_we;
    logic [7:0]            work_q;
    logic [7:0]            work_mem [2**`PROT_RAM_AW];

    assign region = prot_bus_pkg::addr_region(bus_addr);

    assign work_we   = bus_wr && (region == prot_bus_pkg::WORK);
    assign shd_we    = bus_wr && (region == prot_bus_pkg::SHARED);
    assign shd_addr  = bus_addr[`PROT_RAM_AW-1:0];   // low bits index either ram
    assign shd_wdata = bus_wdata;

    // work ram, registered read like the shared ram
    always_ff @(posedge clk) begin
        if (work_we) begin
            work_mem[bus_addr[`PROT_RAM_AW-1:0]] <= bus_wdata;
        end
        work_q <= work_mem[bus_addr[`PROT_RAM_AW-1:0]];
    end

    // mux select registered in step with both ram outputs
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_pend   <= 1'b0;
            rd_region <= prot_bus_pkg::WORK;
        end else begin
            rd_pend   <= bus_rd;
            rd_region <= region;
        end
    end

    // idle bus floats high
    assign bus_rdata = !rd_pend ? 8'hff :
                       (rd_region == prot_bus_pkg::SHARED) ? shd_q : work_q;

endmodule

/* rtl/prot_irq.sv */
// mailbox interrupt
// any main access to the mailbox byte raises irq, which then
// holds for a fixed count and clears itself
`include "prot_config.svh"

module prot_irq (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`PROT_RAM_AW-1:0] main_addr,
    input  logic                    main_cs,
    output logic                    irq
);

    logic       set_irq;
    logic [7:0] cnt;   // hold countdown

    // read or write, both count as a kick
    assign set_irq = main_cs && (main_addr == `PROT_MAILBOX);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt <= 8'd0;
            irq <= 1'b0;
        end else if (set_irq) begin
            cnt <= `PROT_IRQ_HOLD;   // a new kick reloads
            irq <= 1'b1;
        end else begin
            if (cnt != 8'd0) begin
                cnt <= cnt - 8'd1;   // runs on down to 0
            end
            if (cnt == 8'd1) begin
                irq <= 1'b0;   // hold expired
            end
        end
    end

endmodule

/* rtl/prot_dpram.sv */
// true dual-port ram, registered read on both ports
// port a wins when both ports write the same word
module prot_dpram #(
    parameter int aw = 11,
    parameter int dw = 8
) (
    input  logic          clk,
    // port a
    input  logic [aw-1:0] addr_a,
    input  logic [dw-1:0] wdata_a,
    input  logic          we_a,
    output logic [dw-1:0] q_a,
    // port b
    input  logic [aw-1:0] addr_b,
    input  logic [dw-1:0] wdata_b,
    input  logic          we_b,
    output logic [dw-1:0] q_b
);

    logic [dw-1:0] mem [2**aw];

    always_ff @(posedge clk) begin
        // b first so a overrides on a same-word collision
        if (we_b) begin
            mem[addr_b] <= wdata_b;
        end
        if (we_a) begin
            mem[addr_a] <= wdata_a;
        end
        q_a <= mem[addr_a];   // old data on read during write
        q_b <= mem[addr_b];
    end

endmodule

/* rtl/prot_bus_pkg.sv */
// coprocessor data bus definitions
// 12-bit address, top bit splits work ram from shared ram
`include "prot_config.svh"

package prot_bus_pkg;

    typedef logic [`PROT_RAM_AW:0] bus_addr_t;

    typedef enum logic {
        WORK   = 1'b0,   // 0x000-0x7ff, private work ram
        SHARED = 1'b1    // 0x800-0xfff, shared with main
    } region_e;

    // region from the top address bit
    function automatic region_e addr_region(bus_addr_t a);
        return region_e'(a[`PROT_RAM_AW]);
    endfunction

endpackage

/* rtl/prot_isa_pkg.sv */
// protection coprocessor instruction set
// 16-bit words, opcode always in the top nibble
// two decodings of the same word: memory/jump form and immediate form
package prot_isa_pkg;

    typedef enum logic [3:0] {
        NOP  = 4'h0,  // no operation
        LDI  = 4'h1,  // acc = imm
        LD   = 4'h2,  // acc = mem[addr]
        ST   = 4'h3,  // mem[addr] = acc
        ADD  = 4'h4,  // acc = acc + mem[addr], wraps
        XOR  = 4'h5,  // acc = acc ^ mem[addr]
        JMP  = 4'h6,  // pc = addr
        JZ   = 4'h7,  // pc = addr when acc is zero
        WAI  = 4'h8,  // wait on irq level, addr[0] picks the level
        HALT = 4'h9   // stop until reset
    } opcode_e;

    // memory form, also used by jumps (low bits only) and WAI
    typedef struct packed {
        opcode_e     op;
        logic [11:0] addr;   // bus address or program address
    } instr_mem_t;

    // immediate form for LDI
    typedef struct packed {
        opcode_e    op;
        logic [3:0] pad;     // ignored
        logic [7:0] imm;
    } instr_imm_t;

    typedef union packed {
        instr_mem_t mem;
        instr_imm_t imm;
    } instr_u;

endpackage

/* rtl/prot_config.svh */
// protection coprocessor configuration
// memory sizes, mailbox location and irq hold time
`ifndef PROT_CONFIG_SVH
`define PROT_CONFIG_SVH

// program rom address width, 512 words of 16 bits
`define PROT_PROG_AW 9

// work ram and shared ram address width, 2 kB each
`define PROT_RAM_AW 11

// last shared byte, any main access here kicks the coprocessor
`define PROT_MAILBOX 11'h7ff

// irq hold counter reload value, irq drops when the count hits 1
`define PROT_IRQ_HOLD 8'd255

`endif
